/* all.f */
hw/scan_pkg.sv
hw/scan_bus_if.sv
hw/frame_sync.sv
hw/addr_match.sv
hw/ones_chksum.sv
hw/header_patt.sv
hw/crc32_check.sv
hw/scanner.sv
verification/tb_clock.sv
verification/scanner_sva.sv
verification/scanner_tb.sv

/* hw/addr_match.sv */
`timescale 1ns/1ps

module addr_match import scan_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	scan_bus_if.sink   bus,
	output logic [3:0] ip_a,
	input  logic [7:0] ip_d,
	output logic       pass_ethmac,
	output logic       pass_arpip,
	output logic       pass_ipdst,
	output logic       unicast_src,
	output logic       drop
);

	logic [10:0] idx;
	logic start, in_ip_win, ip_m;
	logic want_mac, want_arp, want_ip;

	// IP fields sit at 30..33 and 38..41, both land on 6..9 after the shift
	assign in_ip_win = bus.cnt >= cfg_ip_lo && bus.cnt <= cfg_ip_hi;
	assign ip_a = in_ip_win ? bus.cnt[3:0] + cfg_ip_bias : bus.cnt[3:0];

	// Memory answers one cycle later, next to the delayed octet
	assign idx  = bus.cnt - 11'd1;
	assign ip_m = ip_d == bus.data;

	assign start    = bus.cnt == 11'd0;
	assign want_mac = bus.gate && idx < cfg_mac_len;
	assign want_arp = bus.gate && idx >= off_arp_tpa && idx < off_arp_tpa + cfg_ip_len;
	assign want_ip  = bus.gate && idx >= off_ip_dst && idx < off_ip_dst + cfg_ip_len;

	// Match flags start optimistic and fall on any mismatch
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pass_ethmac <= 1'b0;
			pass_arpip  <= 1'b0;
			pass_ipdst  <= 1'b0;
			unicast_src <= 1'b0;
		end else if (start) begin
			pass_ethmac <= 1'b1;
			pass_arpip  <= 1'b1;
			pass_ipdst  <= 1'b1;
			unicast_src <= 1'b1;
		end else begin
			if (want_mac && !ip_m) pass_ethmac <= 1'b0;
			if (want_arp && !ip_m) pass_arpip <= 1'b0;
			if (want_ip && !ip_m) pass_ipdst <= 1'b0;
			// Group bit of the source MAC
			if (bus.gate && idx == off_src_mac) unicast_src <= ~bus.data[0];
		end
	end

	// Oversize frame ends the data state
	assign drop = bus.cnt >= max_frame_len;

endmodule

/* hw/crc32_check.sv */
`timescale 1ns/1ps

module crc32_check import scan_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	scan_bus_if.sink bus,
	output logic     crc_ok
);

	logic [31:0] crc_q;
	logic [31:0] crc_seed;

	// One octet of the reflected CRC, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r >> 1) ^ ((r[0] ^ d[i]) ? crc_poly : 32'd0);
		end
		return r;
	endfunction

	// Preset folds into the update of octet 0
	assign crc_seed = bus.first ? 32'hffffffff : crc_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q <= 32'hffffffff;
		end else if (bus.gate) begin
			crc_q <= crc_byte(crc_seed, bus.data);
		end
	end

	// FCS included so a good frame leaves the fixed residue
	assign crc_ok = crc_q == crc_residue;

endmodule

/* hw/frame_sync.sv */
`timescale 1ns/1ps

module frame_sync import scan_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] eth_in,
	input  logic       eth_in_s,
	input  logic       enable_rx,
	scan_bus_if.src    bus,
	input  logic       drop,
	output logic [7:0] odata,
	output logic       odata_s,
	output logic       odata_f
);

	// One-hot receive states
	logic st_idle, st_pre, st_data, st_drop;
	logic [3:0] ifg_cnt;
	logic ifg_ok;
	logic [10:0] pack_cnt;
	logic data_v_d1, first_q, odata_s_q;
	logic [7:0] data_d1, data_d2;
	logic last;

	// Gap counted over idle cycles only, preamble octets hold it
	// Saturates at 12 and starts full out of reset
	assign ifg_ok = ifg_cnt >= ifg_min;
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ifg_cnt <= 4'd12;
		end else if (st_idle) begin
			ifg_cnt <= ifg_cnt + {3'd0, ~&ifg_cnt[3:2]};
		end else if (!st_pre) begin
			ifg_cnt <= 4'd0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			st_idle <= 1'b1;
			st_pre  <= 1'b0;
			st_data <= 1'b0;
			st_drop <= 1'b0;
		end else begin
			// First octet must be preamble with the receiver enabled
			if (st_idle && eth_in_s) begin
				st_idle <= 1'b0;
				if (eth_in == oct_preamble && enable_rx) st_pre <= 1'b1;
				else st_drop <= 1'b1;
			end
			if (st_pre) begin
				if (eth_in_s && eth_in == oct_sfd) begin
					st_pre <= 1'b0;
					// Short gap ends up in drop
					if (ifg_ok) st_data <= 1'b1;
					else st_drop <= 1'b1;
				end else if (eth_in_s && eth_in != oct_preamble) begin
					st_pre  <= 1'b0;
					st_drop <= 1'b1;
				end else if (!eth_in_s) begin
					st_pre  <= 1'b0;
					st_idle <= 1'b1;
				end
			end
			if (st_data) begin
				if (!eth_in_s) begin
					st_data <= 1'b0;
					st_idle <= 1'b1;
				end else if (drop) begin
					st_data <= 1'b0;
					st_drop <= 1'b1;
				end
			end
			// Wait out the rest of a rejected frame
			if (st_drop && !eth_in_s) begin
				st_drop <= 1'b0;
				st_idle <= 1'b1;
			end
		end
	end

	// Octet counter and valid pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pack_cnt  <= 11'd0;
			data_v_d1 <= 1'b0;
			first_q   <= 1'b0;
			odata_s_q <= 1'b0;
		end else begin
			pack_cnt  <= st_data ? pack_cnt + 11'd1 : 11'd0;
			data_v_d1 <= st_data;
			first_q   <= st_data & ~data_v_d1;
			odata_s_q <= st_data & data_v_d1;
		end
	end

	// Two-stage octet delay
	always_ff @(posedge clk) begin
		data_d1 <= eth_in_s ? eth_in : 8'd0;
		data_d2 <= data_d1;
	end

	// st_data runs one cycle past the final octet
	assign last = data_v_d1 & ~st_data;

	assign bus.cnt   = pack_cnt;
	assign bus.data  = data_d1;
	assign bus.gate  = st_data & data_v_d1;
	assign bus.first = first_q;
	assign bus.last  = last;

	assign odata   = data_d2;
	assign odata_s = odata_s_q;
	assign odata_f = last;

endmodule

/* hw/header_patt.sv */
`timescale 1ns/1ps

module header_patt import scan_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	scan_bus_if.sink bus,
	output logic     pass_arp,
	output logic     pass_ip,
	output logic     pass_icmp,
	output logic     pass_udp,
	output logic     len_ok
);

	logic [10:0] idx, arp_pos, ip_pos;
	logic start;
	logic [7:0] data_prev;
	logic [15:0] ip_len, udp_len;
	logic [16:0] ip_end;
	logic arp_want, arp_hit, ip_want, ip_hit;
	logic icmp_want, icmp_hit, udp_want, udp_hit;
	logic ip_gate, icmp_gate, ip_ones, icmp_ones, icmp_end;
	logic arp_ok, ip_ok, icmp_ok, udp_ok;
	logic ip_sum_bad, icmp_sum_bad, udp_len_bad, len_ok_q;

	// Index of the octet on bus.data
	assign idx     = bus.cnt - 11'd1;
	assign start   = bus.cnt == 11'd0;
	assign arp_pos = idx - off_ethertype;
	assign ip_pos  = idx - off_ethertype;

	// First octet past the IP datagram
	assign ip_end = {1'b0, ip_len} + {6'd0, eth_hdr_len};

	always_comb begin
		arp_want  = idx >= off_ethertype && idx < off_ethertype + 11'd10;
		arp_hit   = bus.data == arp_tmpl[arp_pos[3:0]];
		ip_want   = 1'b0;
		ip_hit    = 1'b1;
		icmp_want = 1'b0;
		icmp_hit  = 1'b1;
		udp_want  = 1'b0;
		udp_hit   = 1'b1;
		// Ethertype 0800 and version/IHL 45
		if (idx >= off_ethertype && idx < off_ethertype + 11'd3) begin
			ip_want = 1'b1;
			ip_hit  = bus.data == ip_tmpl[ip_pos[1:0]];
		end
		// No fragments, DF may be set
		if (idx == off_ip_flags) begin
			ip_want = 1'b1;
			ip_hit  = (bus.data & 8'hbf) == 8'h00;
		end
		if (idx == off_ip_flags + 11'd1) begin
			ip_want = 1'b1;
			ip_hit  = bus.data == 8'h00;
		end
		// Expired packet
		if (idx == off_ttl) begin
			ip_want = 1'b1;
			ip_hit  = bus.data != 8'h00;
		end
		if (idx == off_proto) begin
			icmp_want = 1'b1;
			icmp_hit  = bus.data == proto_icmp;
			udp_want  = 1'b1;
			udp_hit   = bus.data == proto_udp;
		end
		// ICMP type and UDP source port share octet 34
		if (idx == off_icmp_type) begin
			icmp_want = 1'b1;
			icmp_hit  = bus.data == icmp_echo_req;
		end
		if (idx == off_icmp_type + 11'd1) begin
			icmp_want = 1'b1;
			icmp_hit  = bus.data == 8'h00;
		end
		// Source ports below 1024 are refused to avoid echo loops
		if (idx == off_udp_src) begin
			udp_want = 1'b1;
			udp_hit  = bus.data[7:2] != 6'd0;
		end
		if (idx == off_udp_dst + 11'd1) begin
			udp_want = 1'b1;
			udp_hit  = {data_prev, bus.data} != 16'd0;
		end
	end

	// Previous octet for 16-bit fields
	always_ff @(posedge clk) begin
		if (bus.gate) data_prev <= bus.data;
	end

	// IP total length and UDP length
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ip_len  <= 16'd0;
			udp_len <= 16'd0;
		end else if (bus.gate) begin
			if (idx == off_ip_len + 11'd1) ip_len <= {data_prev, bus.data};
			if (idx == off_udp_len + 11'd1) udp_len <= {data_prev, bus.data};
		end
	end

	// IP header window and ICMP window up to the datagram end
	assign ip_gate = bus.gate && idx >= eth_hdr_len && idx < eth_hdr_len + ip_hdr_len;
	assign icmp_gate = bus.gate && idx >= off_icmp_type && {6'd0, idx} < ip_end;
	assign icmp_end = {6'd0, idx} == ip_end && idx > off_icmp_type;

	ones_chksum u_ip_sum (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (bus.first),
		.gate     (ip_gate),
		.din      (bus.data),
		.all_ones (ip_ones)
	);

	ones_chksum u_icmp_sum (
		.clk      (clk),
		.rst_n    (rst_n),
		.clear    (bus.first),
		.gate     (icmp_gate),
		.din      (bus.data),
		.all_ones (icmp_ones)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arp_ok       <= 1'b0;
			ip_ok        <= 1'b0;
			icmp_ok      <= 1'b0;
			udp_ok       <= 1'b0;
			ip_sum_bad   <= 1'b0;
			icmp_sum_bad <= 1'b0;
			udp_len_bad  <= 1'b0;
		end else if (start) begin
			arp_ok       <= 1'b1;
			ip_ok        <= 1'b1;
			icmp_ok      <= 1'b1;
			udp_ok       <= 1'b1;
			ip_sum_bad   <= 1'b0;
			icmp_sum_bad <= 1'b0;
			udp_len_bad  <= 1'b0;
		end else begin
			if (bus.gate && arp_want && !arp_hit) arp_ok <= 1'b0;
			if (bus.gate && ip_want && !ip_hit) ip_ok <= 1'b0;
			if (bus.gate && icmp_want && !icmp_hit) icmp_ok <= 1'b0;
			if (bus.gate && udp_want && !udp_hit) udp_ok <= 1'b0;
			// Sums are complete one octet after their window
			if (idx == eth_hdr_len + ip_hdr_len) ip_sum_bad <= ~ip_ones;
			if (icmp_end) icmp_sum_bad <= ~icmp_ones;
			// UDP datagram has to fit in the IP payload
			if (idx == off_udp_len + 11'd2) begin
				udp_len_bad <= {1'b0, ip_len} < {1'b0, udp_len} + {6'd0, ip_hdr_len};
			end
		end
	end

	// Frame long enough for the whole datagram plus FCS
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			len_ok_q <= 1'b0;
		end else if (bus.gate) begin
			len_ok_q <= {6'd0, bus.cnt} >= ip_end + {6'd0, crc_len};
		end
	end

	assign pass_arp  = arp_ok;
	assign pass_ip   = ip_ok & ~ip_sum_bad;
	assign pass_icmp = icmp_ok & ~icmp_sum_bad;
	assign pass_udp  = udp_ok & ~udp_len_bad;
	assign len_ok    = len_ok_q;

endmodule

/* hw/ones_chksum.sv */
`timescale 1ns/1ps

module ones_chksum (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       clear,
	input  logic       gate,
	input  logic [7:0] din,
	output logic       all_ones
);

	logic [15:0] sum;
	logic hi_next;
	logic [16:0] add;

	// Even octets go to the high byte, odd ones to the low byte
	assign add = {1'b0, sum} + (hi_next ? {1'b0, din, 8'h00} : {9'd0, din});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sum     <= 16'd0;
			hi_next <= 1'b1;
		end else if (clear) begin
			sum     <= 16'd0;
			hi_next <= 1'b1;
		end else if (gate) begin
			// End-around carry cannot overflow a second time
			sum     <= add[15:0] + {15'd0, add[16]};
			hi_next <= ~hi_next;
		end
	end

	// Correct checksum field leaves negative zero
	assign all_ones = &sum;

endmodule

/* hw/scan_bus_if.sv */
`timescale 1ns/1ps

// Counted octet stream from the framer to the checkers
interface scan_bus_if;
	// Octet count, runs while a frame is in the data state
	logic [10:0] cnt;
	// Octet one cycle behind eth_in, zero when not strobed
	logic [7:0]  data;
	// data holds a frame octet
	logic        gate;
	// data holds octet 0
	logic        first;
	// Cycle after the final octet, status is sampled here
	logic        last;

	modport src (
		output cnt, data, gate, first, last
	);

	modport sink (
		input cnt, data, gate, first, last
	);

endinterface

/* hw/scan_pkg.sv */
package scan_pkg;

	// Frame limits and GMII framing octets
	localparam logic [10:0] max_frame_len = 11'd1536;
	localparam logic [3:0]  ifg_min       = 4'd10;
	localparam logic [7:0]  oct_preamble  = 8'h55;
	localparam logic [7:0]  oct_sfd       = 8'hd5;

	// Frame category as reported in status bits 1:0
	localparam logic [1:0] cat_other = 2'd0;
	localparam logic [1:0] cat_arp   = 2'd1;
	localparam logic [1:0] cat_icmp  = 2'd2;
	localparam logic [1:0] cat_udp   = 2'd3;

	// Octet offsets after the start delimiter
	localparam logic [10:0] off_src_mac   = 11'd6;
	localparam logic [10:0] off_ethertype = 11'd12;
	localparam logic [10:0] off_ip_len    = 11'd16;
	localparam logic [10:0] off_ip_flags  = 11'd20;
	localparam logic [10:0] off_ttl       = 11'd22;
	localparam logic [10:0] off_proto     = 11'd23;
	localparam logic [10:0] off_ip_dst    = 11'd30;
	localparam logic [10:0] off_icmp_type = 11'd34;
	localparam logic [10:0] off_udp_src   = 11'd34;
	localparam logic [10:0] off_udp_dst   = 11'd36;
	localparam logic [10:0] off_arp_tpa   = 11'd38;
	localparam logic [10:0] off_udp_len   = 11'd38;

	// Header sizes
	localparam logic [10:0] eth_hdr_len = 11'd14;
	localparam logic [10:0] ip_hdr_len  = 11'd20;
	localparam logic [10:0] crc_len     = 11'd4;

	// Reflected Ethernet polynomial and good-frame residue
	localparam logic [31:0] crc_poly    = 32'hedb88320;
	localparam logic [31:0] crc_residue = 32'hdebb20e3;

	// Config memory: MAC at 0..5, IPv4 at 6..9
	localparam logic [10:0] cfg_mac_len = 11'd6;
	localparam logic [10:0] cfg_ip_len  = 11'd4;
	localparam logic [10:0] cfg_ip_lo   = 11'd16;
	localparam logic [10:0] cfg_ip_hi   = 11'd36;
	localparam logic [3:0]  cfg_ip_bias = 4'd8;

	// ARP request template from the ethertype up to the opcode
	localparam logic [0:9][7:0] arp_tmpl = {8'h08, 8'h06, 8'h00, 8'h01, 8'h08,
		8'h00, 8'h06, 8'h04, 8'h00, 8'h01};
	// IPv4 ethertype and version/IHL
	localparam logic [0:2][7:0] ip_tmpl = {8'h08, 8'h00, 8'h45};

	localparam logic [7:0] proto_icmp    = 8'h01;
	localparam logic [7:0] proto_udp     = 8'h11;
	localparam logic [7:0] icmp_echo_req = 8'h08;

endpackage

/* hw/scanner.sv */
`timescale 1ns/1ps

module scanner import scan_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  eth_in,
	input  logic        eth_in_s,
	input  logic        enable_rx,
	output logic [3:0]  ip_a,
	input  logic [7:0]  ip_d,
	output logic        busy,
	output logic        keep,
	output logic [7:0]  odata,
	output logic        odata_s,
	output logic        odata_f,
	output logic        status_valid,
	output logic [7:0]  status_vec,
	output logic [10:0] pack_len
);

	scan_bus_if bus ();

	logic drop, pass_ethmac, pass_arpip, pass_ipdst, unicast_src;
	logic pass_arp, pass_ip, pass_icmp, pass_udp, len_ok, crc_ok;
	logic arp_all, ip_all, icmp_all, udp_all;
	logic cand_arp, cand_icmp, cand_udp;
	logic [1:0] category;
	logic [7:0] status_now, status_q;
	logic [10:0] len_now, len_q;
	logic busy_q, keep_q;

	frame_sync u_sync (
		.clk       (clk),
		.rst_n     (rst_n),
		.eth_in    (eth_in),
		.eth_in_s  (eth_in_s),
		.enable_rx (enable_rx),
		.bus       (bus.src),
		.drop      (drop),
		.odata     (odata),
		.odata_s   (odata_s),
		.odata_f   (odata_f)
	);

	addr_match u_addr (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (bus.sink),
		.ip_a        (ip_a),
		.ip_d        (ip_d),
		.pass_ethmac (pass_ethmac),
		.pass_arpip  (pass_arpip),
		.pass_ipdst  (pass_ipdst),
		.unicast_src (unicast_src),
		.drop        (drop)
	);

	header_patt u_patt (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus       (bus.sink),
		.pass_arp  (pass_arp),
		.pass_ip   (pass_ip),
		.pass_icmp (pass_icmp),
		.pass_udp  (pass_udp),
		.len_ok    (len_ok)
	);

	crc32_check u_crc (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (bus.sink),
		.crc_ok (crc_ok)
	);

	// Each category needs a good CRC and a unicast sender
	assign arp_all  = unicast_src & crc_ok & pass_arp & pass_arpip;
	assign ip_all   = unicast_src & crc_ok & pass_ethmac & pass_ip & pass_ipdst & len_ok;
	assign icmp_all = ip_all & pass_icmp;
	assign udp_all  = ip_all & pass_udp;
	assign category = udp_all ? cat_udp : icmp_all ? cat_icmp : arp_all ? cat_arp : cat_other;

	// No port CAM here so bits 7:5 stay zero
	assign status_now = {3'b000, ip_all, pass_ethmac, crc_ok, category};
	// Count is two past the final octet in the status cycle
	assign len_now = bus.cnt - 11'd2;

	// Hold the summary until the next frame reports
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status_q <= 8'd0;
			len_q    <= 11'd0;
		end else if (bus.last) begin
			status_q <= status_now;
			len_q    <= len_now;
		end
	end

	assign status_valid = bus.last;
	assign status_vec   = bus.last ? status_now : status_q;
	assign pack_len     = bus.last ? len_now : len_q;

	// Candidates from the templates alone, before checksums and CRC are known
	assign cand_arp  = unicast_src & pass_arp;
	assign cand_icmp = unicast_src & pass_ethmac & pass_ip & pass_icmp;
	assign cand_udp  = unicast_src & pass_ethmac & pass_ip & pass_udp;

	// busy trails odata_s by a cycle, keep lands on its final octet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			keep_q <= 1'b0;
		end else begin
			busy_q <= odata_s & (cand_arp | cand_icmp | cand_udp);
			keep_q <= odata_s & (category != cat_other);
		end
	end

	assign busy = busy_q;
	assign keep = keep_q;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module scanner_tb -f all.f \
	-o scanner_sim &&
./obj_dir/scanner_sim +verilator+error+limit+1000 | tee /dev/stderr | \
	grep -x "RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verification/scanner_sva.sv */
`timescale 1ns/1ps

module scanner_sva import scan_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input logic [7:0]  eth_in,
	input logic        eth_in_s,
	input logic [7:0]  odata,
	input logic        odata_s,
	input logic        odata_f,
	input logic        status_valid,
	input logic [7:0]  status_vec,
	input logic [10:0] pack_len,
	input logic        busy,
	input logic        keep
);

	// Expected summary of the frame in flight, written by the testbench
	logic [7:0]  exp_status;
	logic [10:0] exp_len;
	// Frame on the wire must not reach the output
	logic        no_rx;
	int          fail_cnt;

	initial begin
		exp_status = 8'd0;
		exp_len    = 11'd0;
		no_rx      = 1'b0;
		fail_cnt   = 0;
	end

	a_status: assert property (@(posedge clk) disable iff (!rst_n)
		status_valid |-> status_vec == exp_status)
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t status_vec expected %h got %h", $time, exp_status,
			status_vec);
	end

	a_len: assert property (@(posedge clk) disable iff (!rst_n)
		status_valid |-> pack_len == exp_len)
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t pack_len expected %0d got %0d", $time, exp_len, pack_len);
	end

	// Output octet is the strobed input octet from two cycles back
	a_odata: assert property (@(posedge clk) disable iff (!rst_n)
		odata_s |-> $past(eth_in_s, 2) && odata == $past(eth_in, 2))
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t odata expected %h got %h", $time, $past(eth_in, 2), odata);
	end

	a_status_f: assert property (@(posedge clk) disable iff (!rst_n)
		status_valid == odata_f)
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t status_valid expected %b got %b", $time, odata_f,
			status_valid);
	end

	// Kept frame: keep and busy both high right after the status cycle
	a_keep: assert property (@(posedge clk) disable iff (!rst_n)
		status_valid && exp_status[1:0] != cat_other |=> keep && busy)
	else begin
		fail_cnt++;
		$error("Kept frame without keep and busy after its status at %0t", $time);
	end

	// and busy gone one cycle later
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$past(status_valid && exp_status[1:0] != cat_other, 2) |-> !busy)
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t busy expected 0 got %b", $time, busy);
	end

	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!odata_s && $past(!odata_s) |-> !busy && !keep)
	else begin
		fail_cnt++;
		$error("busy or keep high with the output idle at %0t", $time);
	end

	a_no_rx: assert property (@(posedge clk) disable iff (!rst_n)
		no_rx |-> !odata_s)
	else begin
		fail_cnt++;
		$error("CHECK FAILED at %0t odata_s expected 0 got %b", $time, odata_s);
	end

endmodule

bind scanner scanner_sva u_sva (.*);

/* verification/scanner_tb.sv */
`timescale 1ns/1ps

module scanner_tb;

	logic clk, rst_n;
	logic [7:0] eth_in, ip_d, odata, status_vec;
	logic eth_in_s, enable_rx;
	logic [3:0] ip_a;
	logic busy, keep, odata_s, odata_f, status_valid;
	logic [10:0] pack_len;

	// Configuration memory, MAC at 0..5 and IPv4 at 6..9
	logic [7:0] cfg_mem [0:15];
	// Frame under construction, octets after the SFD
	logic [7:0] frm [0:127];
	int frm_len;
	int status_cnt;
	int tb_errs;
	int tests;
	int failed;
	int errs_before;
	int seen;

	tb_clock u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	scanner DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.eth_in       (eth_in),
		.eth_in_s     (eth_in_s),
		.enable_rx    (enable_rx),
		.ip_a         (ip_a),
		.ip_d         (ip_d),
		.busy         (busy),
		.keep         (keep),
		.odata        (odata),
		.odata_s      (odata_s),
		.odata_f      (odata_f),
		.status_valid (status_valid),
		.status_vec   (status_vec),
		.pack_len     (pack_len)
	);

	// Memory answers one cycle after the address
	always @(posedge clk) begin
		ip_d <= cfg_mem[ip_a];
	end

	// Status pulses seen so far
	always @(posedge clk) begin
		if (status_valid) status_cnt <= status_cnt + 1;
	end

	function automatic logic [7:0] status_for(input logic crc_good, input logic mac_hit,
		input logic ip_good, input logic [1:0] cand);
		logic ip_valid;
		logic [1:0] cat;
		ip_valid = crc_good & mac_hit & ip_good;
		cat = 2'd0;
		// ARP needs only the CRC, IP kinds need a valid IP frame
		if (cand == 2'd1 && crc_good) cat = 2'd1;
		if (cand >= 2'd2 && ip_valid) cat = cand;
		return {3'b000, ip_valid, mac_hit, crc_good, cat};
	endfunction

	// One's-complement sum of big-endian words over frm[from..to-1]
	function automatic logic [15:0] ones_sum(input int from, input int to);
		logic [31:0] s;
		s = 32'd0;
		for (int i = from; i < to; i += 2) begin
			s += {frm[i], (i + 1 < to) ? frm[i + 1] : 8'h00};
		end
		s = s[15:0] + s[31:16];
		s = s[15:0] + s[31:16];
		return s[15:0];
	endfunction

	task automatic put16(input int pos, input logic [15:0] v);
		frm[pos]     = v[15:8];
		frm[pos + 1] = v[7:0];
	endtask

	// Ethernet header, source 02:aa:bb:cc:dd:01 is unicast
	task automatic start_eth(input bit bcast, input bit wrong_mac, input logic [15:0] etype);
		for (int i = 0; i < 6; i++) begin
			frm[i] = bcast ? 8'hff : cfg_mem[i];
		end
		if (wrong_mac) frm[5] = frm[5] ^ 8'h01;
		frm[6] = 8'h02;
		frm[7] = 8'haa;
		frm[8] = 8'hbb;
		frm[9] = 8'hcc;
		frm[10] = 8'hdd;
		frm[11] = 8'h01;
		put16(12, etype);
	endtask

	task automatic build_ip(input logic [7:0] proto, input int ip_len);
		put16(14, 16'h4500);
		put16(16, ip_len[15:0]);
		put16(18, 16'h1234);
		// DF set, no fragment
		put16(20, 16'h4000);
		frm[22] = 8'h40;
		frm[23] = proto;
		put16(24, 16'h0000);
		put16(26, 16'h0a00);
		put16(28, 16'h0001);
		for (int i = 0; i < 4; i++) begin
			frm[30 + i] = cfg_mem[6 + i];
		end
		put16(24, ~ones_sum(14, 34));
	endtask

	// Reflected CRC32, appended low octet first
	task automatic add_fcs();
		logic [31:0] c;
		c = 32'hffffffff;
		for (int i = 0; i < frm_len; i++) begin
			for (int b = 0; b < 8; b++) begin
				if (c[0] ^ frm[i][b]) c = (c >> 1) ^ 32'hedb88320;
				else c = c >> 1;
			end
		end
		c = ~c;
		for (int k = 0; k < 4; k++) begin
			frm[frm_len + k] = c[8 * k +: 8];
		end
		frm_len += 4;
	endtask

	task automatic build_arp();
		start_eth(1'b1, 1'b0, 16'h0806);
		put16(14, 16'h0001);
		put16(16, 16'h0800);
		frm[18] = 8'h06;
		frm[19] = 8'h04;
		put16(20, 16'h0001);
		for (int i = 0; i < 6; i++) begin
			frm[22 + i] = frm[6 + i];
			frm[32 + i] = 8'h00;
		end
		put16(28, 16'h0a00);
		put16(30, 16'h0001);
		for (int i = 0; i < 4; i++) begin
			frm[38 + i] = cfg_mem[6 + i];
		end
		// Pad to the minimum frame
		for (int i = 42; i < 60; i++) begin
			frm[i] = 8'h00;
		end
		frm_len = 60;
		add_fcs();
	endtask

	task automatic build_icmp(input bit bad_sum);
		start_eth(1'b0, 1'b0, 16'h0800);
		build_ip(8'h01, 20 + 8 + 32);
		put16(34, 16'h0800);
		put16(36, 16'h0000);
		put16(38, 16'h0001);
		put16(40, 16'h0001);
		for (int i = 42; i < 74; i++) begin
			frm[i] = $urandom;
		end
		put16(36, ~ones_sum(34, 74));
		if (bad_sum) frm[37] = frm[37] ^ 8'h01;
		frm_len = 74;
		add_fcs();
	endtask

	task automatic build_udp(input logic [15:0] src, input bit wrong_mac);
		start_eth(1'b0, wrong_mac, 16'h0800);
		build_ip(8'h11, 20 + 8 + 24);
		put16(34, src);
		put16(36, 16'd7);
		put16(38, 16'd32);
		put16(40, 16'h0000);
		for (int i = 42; i < 66; i++) begin
			frm[i] = $urandom;
		end
		frm_len = 66;
		add_fcs();
	endtask

	task automatic drive(input logic [7:0] b);
		@(posedge clk);
		eth_in   <= b;
		eth_in_s <= 1'b1;
	endtask

	// Preamble, SFD, frame, then gap idle cycles
	task automatic send_frame(input int gap);
		for (int i = 0; i < 7; i++) begin
			drive(8'h55);
		end
		drive(8'hd5);
		for (int i = 0; i < frm_len; i++) begin
			drive(frm[i]);
		end
		for (int g = 0; g < gap; g++) begin
			@(posedge clk);
			eth_in   <= 8'h00;
			eth_in_s <= 1'b0;
		end
	endtask

	task automatic expect_frame(input logic [7:0] st);
		DUT.u_sva.exp_status = st;
		DUT.u_sva.exp_len = 11'(frm_len - 1);
	endtask

	task automatic wait_status(input int target);
		int n;
		n = 0;
		while (status_cnt < target && n < 500) begin
			@(posedge clk);
			n++;
		end
		if (status_cnt < target) begin
			tb_errs++;
			$display("Timeout waiting for status_valid at %0t", $time);
		end
	endtask

	task automatic begin_test();
		errs_before = DUT.u_sva.fail_cnt + tb_errs;
		seen = status_cnt;
	endtask

	task automatic end_test(input string name);
		// Let the trailing busy/keep checks run
		repeat (3) @(posedge clk);
		tests++;
		if (DUT.u_sva.fail_cnt + tb_errs == errs_before) begin
			$display("test %-12s ok", name);
		end else begin
			failed++;
			$display("test %-12s failed", name);
		end
	endtask

	// Run one frame that should report the given status
	task automatic check_frame(input string name, input logic [7:0] st);
		begin_test();
		expect_frame(st);
		send_frame(12);
		wait_status(seen + 1);
		end_test(name);
	endtask

	initial begin
		int n;
		void'($urandom(32'hedc8));
		eth_in = 8'h00;
		eth_in_s = 1'b0;
		enable_rx = 1'b1;
		ip_d = 8'h00;
		status_cnt = 0;
		tb_errs = 0;
		tests = 0;
		failed = 0;
		for (int a = 0; a < 16; a++) begin
			cfg_mem[a] = {a[3:0], ~a[3:0]};
		end
		cfg_mem[0] = 8'h02;
		cfg_mem[1] = 8'h12;
		cfg_mem[2] = 8'h34;
		cfg_mem[3] = 8'h56;
		cfg_mem[4] = 8'h78;
		cfg_mem[5] = 8'h9a;
		cfg_mem[6] = 8'hc0;
		cfg_mem[7] = 8'ha8;
		cfg_mem[8] = 8'h01;
		cfg_mem[9] = 8'h0a;

		n = 0;
		while (rst_n !== 1'b1 && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			tb_errs++;
			$display("Reset never released");
		end
		repeat (4) @(posedge clk);

		build_arp();
		check_frame("arp", status_for(1'b1, 1'b0, 1'b0, 2'd1));
		build_icmp(1'b0);
		check_frame("icmp", status_for(1'b1, 1'b1, 1'b1, 2'd2));
		build_icmp(1'b1);
		check_frame("icmp_badsum", status_for(1'b1, 1'b1, 1'b1, 2'd0));
		// Source ports from 1024 up are accepted
		build_udp(16'd5000, 1'b0);
		check_frame("udp_5000", status_for(1'b1, 1'b1, 1'b1, 2'd3));
		build_udp(16'd53, 1'b0);
		check_frame("udp_53", status_for(1'b1, 1'b1, 1'b1, 2'd0));
		build_udp(16'd5000, 1'b0);
		frm[frm_len - 1] = frm[frm_len - 1] ^ 8'h01;
		check_frame("fcs_flip", status_for(1'b0, 1'b1, 1'b1, 2'd3));
		build_udp(16'd5000, 1'b1);
		check_frame("wrong_mac", status_for(1'b1, 1'b0, 1'b1, 2'd3));

		// Receiver disabled on the first preamble octet
		begin_test();
		build_udp(16'd5000, 1'b0);
		@(posedge clk);
		enable_rx <= 1'b0;
		DUT.u_sva.no_rx = 1'b1;
		send_frame(12);
		DUT.u_sva.no_rx = 1'b0;
		enable_rx <= 1'b1;
		if (status_cnt != seen) begin
			tb_errs++;
			$display("Frame reported with the receiver disabled");
		end
		end_test("rx_disabled");

		// Good frame, then a frame after only 6 idle cycles
		begin_test();
		build_udp(16'd5000, 1'b0);
		expect_frame(status_for(1'b1, 1'b1, 1'b1, 2'd3));
		send_frame(6);
		DUT.u_sva.no_rx = 1'b1;
		send_frame(12);
		DUT.u_sva.no_rx = 1'b0;
		wait_status(seen + 1);
		if (status_cnt != seen + 1) begin
			tb_errs++;
			$display("Frame after a short gap was not dropped");
		end
		end_test("short_gap");

		$display("tests %0d, failed %0d, assertion errors %0d, other errors %0d", tests,
			failed, DUT.u_sva.fail_cnt, tb_errs);
		if (failed == 0 && tb_errs == 0 && DUT.u_sva.fail_cnt == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Overall run limit
	initial begin
		#2000000;
		$display("Simulation time limit reached");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held over the first 16 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule
